//--- verif/cpu_vectors.txt
# P inst_byte_addr word | D data_byte_addr expected_word
# L led_value | E apb_addr refused while running
P 00000100 80000501
P 00000104 80000312
P 00000108 00800312
P 0000010C 00A00431
P 00000110 9800FF45
P 00000114 00B40652
P 00000118 940F0017
P 0000011C 68000003
P 00000120 68000404
P 00000124 68000805
P 00000128 68000C06
P 0000012C 68001007
P 00000130 48000008
P 00000134 00800988
P 00000138 68001409
P 0000013C 8000010A
P 00000140 8000220B
P 00000144 20000312
P 00000148 800002AA
P 0000014C 24000312
P 00000150 8000770A
P 00000154 8000770B
P 00000158 6800180A
P 0000015C 68001C0B
P 00000160 30005C0C
P 00000164 8000550B
P 00000168 8000550A
P 0000016C 8000660B
P 00000170 6800200C
P 00000174 6800240B
P 00000178 6800280A
P 0000017C 9402A50D
P 00000180 68F0200D
P 00000184 20000000
L 000002A5
E 00002000
E 00001100
E 00003000
D 00000000 0000000D
D 00000004 00000008
D 00000008 000000F7
D 0000000C FFFFFF00
D 00000010 00000F05
D 00000014 0000001A
D 00000018 00000003
D 0000001C 00000022
D 00000020 00000164
D 00000024 00000022
D 00000028 00000003

//--- project.f
hdl/cpu_pkg.sv
hdl/debug_regs.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/cpu_top.sv
verif/tb_checker.sv
verif/tb_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timing --top-module tb_top -f project.f -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Testbench passed" sim.log; then
  exit 0
fi
exit 1

//--- verif/tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import cpu_pkg::*;

  localparam int APB_TIMEOUT = 20;
  localparam int RUN_TIMEOUT = 4000;

  logic                 clk;
  logic                 reset;
  apb_req_t             apb_req;
  apb_rsp_t             apb_rsp;
  logic [LEDR_BITS-1:0] ledr;

  // expectations handed to the checker
  logic                 chk_en;
  logic                 chk_rdata;
  logic [DBITS-1:0]     exp_rdata;
  logic                 exp_err;
  logic                 led_chk;
  logic [LEDR_BITS-1:0] exp_led;
  int                   check_errors;

  // vectors from the data file
  logic [DBITS-1:0]     p_addr [$];
  logic [DBITS-1:0]     p_word [$];
  logic [DBITS-1:0]     d_addr [$];
  logic [DBITS-1:0]     d_word [$];
  logic [DBITS-1:0]     e_addr [$];
  logic [LEDR_BITS-1:0] led_value;
  int                   timeouts;

  cpu_top dut (
    .clk     (clk),
    .reset   (reset),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .ledr    (ledr)
  );

  tb_checker u_checker (
    .clk       (clk),
    .reset     (reset),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .ledr      (ledr),
    .chk_en    (chk_en),
    .chk_rdata (chk_rdata),
    .exp_rdata (exp_rdata),
    .exp_err   (exp_err),
    .led_chk   (led_chk),
    .exp_led   (exp_led),
    .errors    (check_errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // one apb transfer of a setup and an access cycle
  task automatic apb_xfer(input logic wr, input logic [APB_ABITS-1:0] addr,
                          input logic [DBITS-1:0] wdata, input logic chk_data,
                          input logic [DBITS-1:0] exp_data, input logic err);
    int cnt;
    cnt = 0;
    @(posedge clk);
    apb_req.psel    <= 1'b1;
    apb_req.penable <= 1'b0;
    apb_req.pwrite  <= wr;
    apb_req.paddr   <= addr;
    apb_req.pwdata  <= wdata;
    @(posedge clk);
    apb_req.penable <= 1'b1;
    chk_en          <= 1'b1;
    chk_rdata       <= chk_data;
    exp_rdata       <= exp_data;
    exp_err         <= err;
    // access ends on the edge that sees pready
    do begin
      @(posedge clk);
      cnt++;
    end while (!apb_rsp.pready && cnt < APB_TIMEOUT);
    if (!apb_rsp.pready) begin
      $display("apb transfer to %h got no pready", addr);
      timeouts++;
    end
    apb_req.psel    <= 1'b0;
    apb_req.penable <= 1'b0;
    chk_en          <= 1'b0;
  endtask

  task automatic check_led(input logic [LEDR_BITS-1:0] value);
    @(posedge clk);
    led_chk <= 1'b1;
    exp_led <= value;
    @(posedge clk);
    led_chk <= 1'b0;
  endtask

  task automatic load_vectors();
    int    fd;
    int    n;
    string line;
    string tag;
    logic [DBITS-1:0] a;
    logic [DBITS-1:0] w;
    fd = $fopen("verif/cpu_vectors.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file verif/cpu_vectors.txt");
      timeouts++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // blank and comment lines
        if (line.len() < 3 || line.getc(0) == "#")
          continue;
        w = '0;
        n = $sscanf(line, "%s %h %h", tag, a, w);
        if (tag == "P") begin
          p_addr.push_back(a);
          p_word.push_back(w);
        end else if (tag == "D") begin
          d_addr.push_back(a);
          d_word.push_back(w);
        end else if (tag == "E") begin
          e_addr.push_back(a);
        end else if (tag == "L") begin
          led_value = a[LEDR_BITS-1:0];
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int cnt;
    reset     <= 1'b1;
    apb_req   <= '0;
    chk_en    <= 1'b0;
    chk_rdata <= 1'b0;
    exp_rdata <= '0;
    exp_err   <= 1'b0;
    led_chk   <= 1'b0;
    exp_led   <= '0;
    led_value = '0;
    timeouts  = 0;
    load_vectors();
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    // leds clear out of reset
    check_led('0);

    // program load and readback through the same window
    foreach (p_addr[i])
      apb_xfer(1'b1, DBG_IMEM_BASE | APB_ABITS'(p_addr[i] & 32'h3FC), p_word[i],
               1'b0, '0, 1'b0);
    foreach (p_addr[i])
      apb_xfer(1'b0, DBG_IMEM_BASE | APB_ABITS'(p_addr[i] & 32'h3FC), '0,
               1'b1, p_word[i], 1'b0);

    // start the core
    apb_xfer(1'b1, DBG_CTRL, 32'd1, 1'b0, '0, 1'b0);

    // the program ends with its one led store
    cnt = 0;
    while (ledr == '0 && cnt < RUN_TIMEOUT) begin
      @(posedge clk);
      cnt++;
    end
    if (ledr == '0) begin
      $display("program never wrote the led register");
      timeouts++;
    end
    check_led(led_value);

    // memory windows refused while running and writes dropped
    foreach (e_addr[i]) begin
      apb_xfer(1'b1, APB_ABITS'(e_addr[i]), 32'hDEAD_BEEF, 1'b0, '0, 1'b1);
      apb_xfer(1'b0, APB_ABITS'(e_addr[i]), '0, 1'b0, '0, 1'b1);
    end

    // stop and dump the result words
    apb_xfer(1'b1, DBG_CTRL, 32'd0, 1'b0, '0, 1'b0);
    apb_xfer(1'b0, DBG_CTRL, '0, 1'b1, 32'd0, 1'b0);
    foreach (d_addr[i])
      apb_xfer(1'b0, DBG_DMEM_BASE | APB_ABITS'(d_addr[i] & 32'h3FC), '0,
               1'b1, d_word[i], 1'b0);

    repeat (2) @(posedge clk);
    $display("errors: %0d check, %0d other", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- verif/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic                           clk,
  input  logic                           reset,
  input  cpu_pkg::apb_req_t              apb_req,
  input  cpu_pkg::apb_rsp_t              apb_rsp,
  input  logic [cpu_pkg::LEDR_BITS-1:0]  ledr,
  input  logic                           chk_en,
  input  logic                           chk_rdata,
  input  logic [cpu_pkg::DBITS-1:0]      exp_rdata,
  input  logic                           exp_err,
  input  logic                           led_chk,
  input  logic [cpu_pkg::LEDR_BITS-1:0]  exp_led,
  output int                             errors
);
  import cpu_pkg::*;

  logic access;

  // completed transfer on this edge
  assign access = apb_req.psel && apb_req.penable && apb_rsp.pready;

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      errors <= 0;
    end else begin
      if (access && chk_en) begin
        if (apb_rsp.pslverr !== exp_err) begin
          $display("FAIL %0t pslverr addr %h expected %b actual %b",
                   $time, apb_req.paddr, exp_err, apb_rsp.pslverr);
          errors <= errors + 1;
        end else if (chk_rdata && apb_rsp.prdata !== exp_rdata) begin
          $display("FAIL %0t prdata addr %h expected %h actual %h",
                   $time, apb_req.paddr, exp_rdata, apb_rsp.prdata);
          errors <= errors + 1;
        end
      end
      // led port
      if (led_chk && ledr !== exp_led) begin
        $display("FAIL %0t ledr expected %h actual %h", $time, exp_led, ledr);
        errors <= errors + 1;
      end
    end
  end

endmodule

//--- hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
  input  logic                           clk,
  input  logic                           reset,
  input  cpu_pkg::apb_req_t              apb_req,
  output cpu_pkg::apb_rsp_t              apb_rsp,
  output logic [cpu_pkg::LEDR_BITS-1:0]  ledr
);
  import cpu_pkg::*;

  // debug side
  logic             run;
  mem_port_t        imem_dbg;
  mem_port_t        dmem_dbg;
  logic [DBITS-1:0] imem_rdata;
  logic [DBITS-1:0] dmem_rdata;

  // pipeline latches and feedback paths
  logic [DBITS-1:0] fe_pc;
  inst_u            fe_inst;
  logic             stall;
  id_ex_t           id_ex;
  ex_mem_t          ex_mem;
  mem_wb_t          mem_wb;
  redirect_t        redirect;
  logic [DBITS-1:0] ex_fwd;
  logic [DBITS-1:0] mem_fwd;

  debug_regs u_debug (
    .clk        (clk),
    .reset      (reset),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .imem_rdata (imem_rdata),
    .dmem_rdata (dmem_rdata),
    .run        (run),
    .imem_dbg   (imem_dbg),
    .dmem_dbg   (dmem_dbg)
  );

  fetch_stage u_fetch (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .stall      (stall),
    .redirect   (redirect),
    .imem_dbg   (imem_dbg),
    .imem_rdata (imem_rdata),
    .fe_pc      (fe_pc),
    .fe_inst    (fe_inst)
  );

  decode_stage u_decode (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .fe_pc    (fe_pc),
    .fe_inst  (fe_inst),
    .redirect (redirect),
    .ex_fwd   (ex_fwd),
    .mem_fwd  (mem_fwd),
    .ex_mem   (ex_mem),
    .mem_wb   (mem_wb),
    .stall    (stall),
    .id_ex    (id_ex)
  );

  execute_stage u_execute (
    .clk      (clk),
    .reset    (reset),
    .run      (run),
    .id_ex    (id_ex),
    .ex_fwd   (ex_fwd),
    .redirect (redirect),
    .ex_mem   (ex_mem)
  );

  memory_stage u_memory (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .ex_mem     (ex_mem),
    .dmem_dbg   (dmem_dbg),
    .dmem_rdata (dmem_rdata),
    .mem_fwd    (mem_fwd),
    .mem_wb     (mem_wb),
    .ledr       (ledr)
  );

endmodule

//--- hdl/memory_stage.sv
`timescale 1ns/1ps

module memory_stage (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           run,
  input  cpu_pkg::ex_mem_t               ex_mem,
  input  cpu_pkg::mem_port_t             dmem_dbg,
  output logic [cpu_pkg::DBITS-1:0]      dmem_rdata,
  output logic [cpu_pkg::DBITS-1:0]      mem_fwd,
  output cpu_pkg::mem_wb_t               mem_wb,
  output logic [cpu_pkg::LEDR_BITS-1:0]  ledr
);
  import cpu_pkg::*;

  logic [DBITS-1:0]        dmem [DMEM_WORDS];
  logic [MEM_IDX_BITS-1:0] idx;
  logic                    is_led;
  logic                    store;

  assign idx    = ex_mem.aluout[MEM_IDX_BITS+1:2];
  assign is_led = ex_mem.aluout == ADDR_LEDR;
  // entries left over after a stop never write
  assign store  = run && ex_mem.valid && ex_mem.ctrl.wr_mem;

  assign dmem_rdata = dmem[dmem_dbg.index];
  // load data or alu result, also the forwarding value
  assign mem_fwd    = ex_mem.ctrl.rd_mem ? dmem[idx] : ex_mem.aluout;

  // core and debug writes never overlap, run separates them
  always_ff @(posedge clk) begin
    if (store && !is_led)
      dmem[idx] <= ex_mem.regval2;
    else if (dmem_dbg.we)
      dmem[dmem_dbg.index] <= dmem_dbg.wdata;
  end

  // led register replaces the dmem write at its address
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      ledr <= '0;
    else if (store && is_led)
      ledr <= ex_mem.regval2[LEDR_BITS-1:0];
  end

  // writeback latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      mem_wb <= '0;
    else if (!run)
      mem_wb <= '0;
    else begin
      mem_wb.wr_reg <= ex_mem.valid && ex_mem.ctrl.wr_reg;
      mem_wb.wregno <= ex_mem.wregno;
      mem_wb.regval <= mem_fwd;
    end
  end

  // execute only loads stores while the core runs
  a_store_run: assert property (@(posedge clk) disable iff (reset)
    ex_mem.valid && ex_mem.ctrl.wr_mem |-> $past(run))
    else $error("store reached memory stage while core stopped");

endmodule

//--- hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       run,
  input  cpu_pkg::id_ex_t            id_ex,
  output logic [cpu_pkg::DBITS-1:0]  ex_fwd,
  output cpu_pkg::redirect_t         redirect,
  output cpu_pkg::ex_mem_t           ex_mem
);
  import cpu_pkg::*;

  logic signed [DBITS-1:0] a;
  logic signed [DBITS-1:0] b;
  logic signed [DBITS-1:0] imm;
  logic [DBITS-1:0]        alu;
  logic [DBITS-1:0]        target;
  logic                    br_cond;
  logic                    taken;

  assign a   = id_ex.regval1;
  assign b   = id_ex.regval2;
  assign imm = id_ex.immval;

  // alu, comparisons are signed
  always_comb begin
    case (id_ex.inst.r.op1)
      OP1_ALUR: begin
        case (id_ex.inst.r.op2)
          OP2_EQ:   alu = {{(DBITS-1){1'b0}}, a == b};
          OP2_LT:   alu = {{(DBITS-1){1'b0}}, a < b};
          OP2_LE:   alu = {{(DBITS-1){1'b0}}, a <= b};
          OP2_NE:   alu = {{(DBITS-1){1'b0}}, a != b};
          OP2_ADD:  alu = a + b;
          OP2_AND:  alu = a & b;
          OP2_OR:   alu = a | b;
          OP2_XOR:  alu = a ^ b;
          OP2_SUB:  alu = a - b;
          OP2_NAND: alu = ~(a & b);
          OP2_NOR:  alu = ~(a | b);
          OP2_NXOR: alu = ~(a ^ b);
          OP2_RSHF: alu = a >> b;
          OP2_LSHF: alu = a << b;
          default:  alu = '0;
        endcase
      end
      // address for loads and stores
      OP1_LW, OP1_SW, OP1_ADDI: alu = a + imm;
      OP1_ANDI: alu = a & imm;
      OP1_ORI:  alu = a | imm;
      OP1_XORI: alu = a ^ imm;
      // link value
      OP1_JAL:  alu = id_ex.pc + INST_BYTES;
      default:  alu = '0;
    endcase
  end

  assign ex_fwd = alu;

  always_comb begin
    case (id_ex.inst.i.op1)
      OP1_BEQ: br_cond = a == b;
      OP1_BLT: br_cond = a < b;
      OP1_BLE: br_cond = a <= b;
      OP1_BNE: br_cond = a != b;
      default: br_cond = 1'b0;
    endcase
  end

  // jal is pc-free, branches are relative to their own pc
  assign target = id_ex.ctrl.is_jmp ? a + (imm <<< 2) : id_ex.pc + (imm <<< 2);
  assign taken  = id_ex.ctrl.is_jmp || (id_ex.ctrl.is_br && br_cond);

  // execute latch, drops the wrong-path entry after a redirect
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ex_mem   <= '0;
      redirect <= '0;
    end else if (!run || redirect.taken) begin
      ex_mem   <= '0;
      redirect <= '0;
    end else begin
      ex_mem.valid    <= id_ex.valid;
      ex_mem.ctrl     <= id_ex.ctrl;
      ex_mem.wregno   <= id_ex.wregno;
      ex_mem.aluout   <= alu;
      ex_mem.regval2  <= id_ex.regval2;
      redirect.taken  <= taken;
      redirect.target <= target;
    end
  end

  // decode bubbles carry no control flags
  a_redirect_valid: assert property (@(posedge clk) disable iff (reset)
    redirect.taken |-> $past(id_ex.valid))
    else $error("redirect taken from a bubble");

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       run,
  input  logic [cpu_pkg::DBITS-1:0]  fe_pc,
  input  cpu_pkg::inst_u             fe_inst,
  input  cpu_pkg::redirect_t         redirect,
  input  logic [cpu_pkg::DBITS-1:0]  ex_fwd,
  input  logic [cpu_pkg::DBITS-1:0]  mem_fwd,
  input  cpu_pkg::ex_mem_t           ex_mem,
  input  cpu_pkg::mem_wb_t           mem_wb,
  output logic                       stall,
  output cpu_pkg::id_ex_t            id_ex
);
  import cpu_pkg::*;

  logic [DBITS-1:0]     regs [2**REGNOBITS];
  logic [OP1BITS-1:0]   op1;
  logic [REGNOBITS-1:0] rs;
  logic [REGNOBITS-1:0] rt;
  logic                 is_op2;
  logic                 is_alui;
  ctrl_t                ctrl;
  id_ex_t               id_ex_w;

  // youngest producer wins, regfile write bypass last
  function automatic logic [DBITS-1:0] operand(input logic [REGNOBITS-1:0] rno);
    logic [DBITS-1:0] val;
    if (rno == '0)
      val = '0;
    else if (id_ex.ctrl.wr_reg && id_ex.wregno == rno)
      val = ex_fwd;
    else if (ex_mem.ctrl.wr_reg && ex_mem.wregno == rno)
      val = mem_fwd;
    else if (mem_wb.wr_reg && mem_wb.wregno == rno)
      val = mem_wb.regval;
    else
      val = regs[rno];
    return val;
  endfunction

  // fields common to both formats
  assign op1 = fe_inst.r.op1;
  assign rs  = fe_inst.r.rs;
  assign rt  = fe_inst.r.rt;

  // all zero word is the register-format nop
  assign is_op2  = op1 == OP1_ALUR && fe_inst.r.op2 != OP2_NOP;
  assign is_alui = fe_inst.i.op1 inside {OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI};

  assign ctrl.is_br  = op1 inside {OP1_BEQ, OP1_BLT, OP1_BLE, OP1_BNE};
  assign ctrl.is_jmp = op1 == OP1_JAL;
  assign ctrl.rd_mem = op1 == OP1_LW;
  assign ctrl.wr_mem = op1 == OP1_SW;
  assign ctrl.wr_reg = is_op2 || is_alui || ctrl.is_jmp || ctrl.rd_mem;

  always_comb begin
    id_ex_w.valid   = 1'b1;
    id_ex_w.pc      = fe_pc;
    id_ex_w.inst    = fe_inst;
    id_ex_w.ctrl    = ctrl;
    // rd for register format, rt for immediate writers
    if (is_op2)
      id_ex_w.wregno = fe_inst.r.rd;
    else if (ctrl.wr_reg)
      id_ex_w.wregno = rt;
    else
      id_ex_w.wregno = '0;
    id_ex_w.regval1 = operand(rs);
    id_ex_w.regval2 = operand(rt);
    // sign extended immediate
    id_ex_w.immval  = {{(DBITS-IMMBITS){fe_inst.i.imm[IMMBITS-1]}}, fe_inst.i.imm};
  end

  // load in execute feeding this instruction
  assign stall = id_ex.ctrl.rd_mem &&
                 ((rs != '0 && id_ex.wregno == rs) || (rt != '0 && id_ex.wregno == rt));

  // r0 stays zero
  always_ff @(posedge clk) begin
    if (mem_wb.wr_reg && mem_wb.wregno != '0)
      regs[mem_wb.wregno] <= mem_wb.regval;
  end

  // decode latch, bubble on stall or flush
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      id_ex <= '0;
    else if (!run || stall || redirect.taken)
      id_ex <= '0;
    else
      id_ex <= id_ex_w;
  end

  // bubble behind a load always clears the hazard
  a_stall_once: assert property (@(posedge clk) disable iff (reset)
    stall |=> !stall)
    else $error("load-use stall held for two cycles");

endmodule

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       run,
  input  logic                       stall,
  input  cpu_pkg::redirect_t         redirect,
  input  cpu_pkg::mem_port_t         imem_dbg,
  output logic [cpu_pkg::DBITS-1:0]  imem_rdata,
  output logic [cpu_pkg::DBITS-1:0]  fe_pc,
  output cpu_pkg::inst_u             fe_inst
);
  import cpu_pkg::*;

  logic [DBITS-1:0] pc;
  logic [DBITS-1:0] inst_w;
  logic [DBITS-1:0] imem [IMEM_WORDS];

  // core read at pc, debug read at its own index
  assign inst_w     = imem[pc[MEM_IDX_BITS+1:2]];
  assign imem_rdata = imem[imem_dbg.index];

  // only the debug port writes instruction memory
  always_ff @(posedge clk) begin
    if (imem_dbg.we)
      imem[imem_dbg.index] <= imem_dbg.wdata;
  end

  // pc select, redirect wins over stall
  always_ff @(posedge clk or posedge reset) begin
    if (reset)
      pc <= START_PC;
    else if (!run)
      pc <= START_PC;
    else if (redirect.taken)
      pc <= redirect.target;
    else if (!stall)
      pc <= pc + INST_BYTES;
  end

  // fetch latch
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fe_pc   <= '0;
      fe_inst <= NOP;
    end else if (!run || redirect.taken) begin
      // wrong path word becomes a nop
      fe_pc   <= '0;
      fe_inst <= NOP;
    end else if (!stall) begin
      fe_pc   <= pc;
      fe_inst <= inst_w;
    end
  end

endmodule

//--- hdl/debug_regs.sv
`timescale 1ns/1ps

module debug_regs (
  input  logic                       clk,
  input  logic                       reset,
  input  cpu_pkg::apb_req_t          apb_req,
  output cpu_pkg::apb_rsp_t          apb_rsp,
  input  logic [cpu_pkg::DBITS-1:0]  imem_rdata,
  input  logic [cpu_pkg::DBITS-1:0]  dmem_rdata,
  output logic                       run,
  output cpu_pkg::mem_port_t         imem_dbg,
  output cpu_pkg::mem_port_t         dmem_dbg
);
  import cpu_pkg::*;

  // window select uses the bits above the 1 KB word range
  localparam int WIN_LSB = MEM_IDX_BITS + 2;

  logic             setup;
  logic             access;
  logic             ctrl_hit;
  logic             imem_hit;
  logic             dmem_hit;
  logic             err;
  logic [DBITS-1:0] rdata;
  logic [DBITS-1:0] prdata_q;
  logic             pslverr_q;

  assign setup  = apb_req.psel && !apb_req.penable;
  assign access = apb_req.psel && apb_req.penable;

  // address decode
  assign ctrl_hit = apb_req.paddr == DBG_CTRL;
  assign imem_hit = apb_req.paddr[APB_ABITS-1:WIN_LSB] == DBG_IMEM_BASE[APB_ABITS-1:WIN_LSB];
  assign dmem_hit = apb_req.paddr[APB_ABITS-1:WIN_LSB] == DBG_DMEM_BASE[APB_ABITS-1:WIN_LSB];

  // memory windows only while the core is stopped
  assign err = (imem_hit || dmem_hit) ? run : !ctrl_hit;

  // read mux, memories return their word at the debug index
  always_comb begin
    if (ctrl_hit)
      rdata = {{(DBITS-1){1'b0}}, run};
    else if (imem_hit && !run)
      rdata = imem_rdata;
    else if (dmem_hit && !run)
      rdata = dmem_rdata;
    else
      rdata = '0;
  end

  // response captured in setup, presented in access
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      run       <= 1'b0;
      prdata_q  <= '0;
      pslverr_q <= 1'b0;
    end else begin
      if (setup) begin
        prdata_q  <= rdata;
        pslverr_q <= err;
      end
      // run bit, core starts at START_PC next cycle
      if (access && apb_req.pwrite && ctrl_hit)
        run <= apb_req.pwdata[0];
    end
  end

  // no wait states
  assign apb_rsp.prdata  = prdata_q;
  assign apb_rsp.pready  = apb_req.penable;
  assign apb_rsp.pslverr = pslverr_q;

  // write strobes only in access, refused writes do nothing
  assign imem_dbg.we    = access && apb_req.pwrite && imem_hit && !err;
  assign imem_dbg.index = apb_req.paddr[WIN_LSB-1:2];
  assign imem_dbg.wdata = apb_req.pwdata;
  assign dmem_dbg.we    = access && apb_req.pwrite && dmem_hit && !err;
  assign dmem_dbg.index = apb_req.paddr[WIN_LSB-1:2];
  assign dmem_dbg.wdata = apb_req.pwdata;

  // access phase must follow a setup phase of the same transfer
  a_apb_phase: assert property (@(posedge clk) disable iff (reset)
    apb_req.penable |-> apb_req.psel && $past(apb_req.psel))
    else $error("apb penable without psel");

endmodule

//--- hdl/cpu_pkg.sv
package cpu_pkg;

  // core widths
  localparam int DBITS = 32;
  localparam int REGNOBITS = 4;
  localparam int OP1BITS = 6;
  localparam int OP2BITS = 8;
  localparam int IMMBITS = 16;

  // memories, word addressed by pc[9:2] and addr[9:2]
  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;
  localparam int MEM_IDX_BITS = $clog2(IMEM_WORDS);

  localparam logic [DBITS-1:0] START_PC = 32'h0000_0100;
  localparam logic [DBITS-1:0] INST_BYTES = 32'd4;
  localparam logic [DBITS-1:0] NOP = '0;

  // memory mapped led register
  localparam logic [DBITS-1:0] ADDR_LEDR = 32'hFFFF_F020;
  localparam int LEDR_BITS = 10;

  // primary opcodes
  localparam logic [OP1BITS-1:0] OP1_ALUR = 6'b000000;
  localparam logic [OP1BITS-1:0] OP1_BEQ  = 6'b001000;
  localparam logic [OP1BITS-1:0] OP1_BLT  = 6'b001001;
  localparam logic [OP1BITS-1:0] OP1_BLE  = 6'b001010;
  localparam logic [OP1BITS-1:0] OP1_BNE  = 6'b001011;
  localparam logic [OP1BITS-1:0] OP1_JAL  = 6'b001100;
  localparam logic [OP1BITS-1:0] OP1_LW   = 6'b010010;
  localparam logic [OP1BITS-1:0] OP1_SW   = 6'b011010;
  localparam logic [OP1BITS-1:0] OP1_ADDI = 6'b100000;
  localparam logic [OP1BITS-1:0] OP1_ANDI = 6'b100100;
  localparam logic [OP1BITS-1:0] OP1_ORI  = 6'b100101;
  localparam logic [OP1BITS-1:0] OP1_XORI = 6'b100110;

  // secondary opcodes, register format only
  localparam logic [OP2BITS-1:0] OP2_NOP  = 8'b00000000;
  localparam logic [OP2BITS-1:0] OP2_EQ   = 8'b00001000;
  localparam logic [OP2BITS-1:0] OP2_LT   = 8'b00001001;
  localparam logic [OP2BITS-1:0] OP2_LE   = 8'b00001010;
  localparam logic [OP2BITS-1:0] OP2_NE   = 8'b00001011;
  localparam logic [OP2BITS-1:0] OP2_ADD  = 8'b00100000;
  localparam logic [OP2BITS-1:0] OP2_AND  = 8'b00100100;
  localparam logic [OP2BITS-1:0] OP2_OR   = 8'b00100101;
  localparam logic [OP2BITS-1:0] OP2_XOR  = 8'b00100110;
  localparam logic [OP2BITS-1:0] OP2_SUB  = 8'b00101000;
  localparam logic [OP2BITS-1:0] OP2_NAND = 8'b00101100;
  localparam logic [OP2BITS-1:0] OP2_NOR  = 8'b00101101;
  localparam logic [OP2BITS-1:0] OP2_NXOR = 8'b00101110;
  localparam logic [OP2BITS-1:0] OP2_RSHF = 8'b00110000;
  localparam logic [OP2BITS-1:0] OP2_LSHF = 8'b00110001;

  // apb debug map, each memory window is 1 KB
  localparam int APB_ABITS = 16;
  localparam logic [APB_ABITS-1:0] DBG_CTRL      = 16'h0000;
  localparam logic [APB_ABITS-1:0] DBG_IMEM_BASE = 16'h1000;
  localparam logic [APB_ABITS-1:0] DBG_DMEM_BASE = 16'h2000;

  // register format, bits 17:12 unused
  typedef struct packed {
    logic [OP1BITS-1:0]   op1;
    logic [OP2BITS-1:0]   op2;
    logic [5:0]           pad;
    logic [REGNOBITS-1:0] rd;
    logic [REGNOBITS-1:0] rs;
    logic [REGNOBITS-1:0] rt;
  } r_fmt_t;

  // immediate format, imm overlaps op2 and rd
  typedef struct packed {
    logic [OP1BITS-1:0]   op1;
    logic [1:0]           pad;
    logic [IMMBITS-1:0]   imm;
    logic [REGNOBITS-1:0] rs;
    logic [REGNOBITS-1:0] rt;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } inst_u;

  typedef struct packed {
    logic is_br;
    logic is_jmp;
    logic rd_mem;
    logic wr_mem;
    logic wr_reg;
  } ctrl_t;

  typedef struct packed {
    logic                 valid;
    logic [DBITS-1:0]     pc;
    inst_u                inst;
    ctrl_t                ctrl;
    logic [REGNOBITS-1:0] wregno;
    logic [DBITS-1:0]     regval1;
    logic [DBITS-1:0]     regval2;
    logic [DBITS-1:0]     immval;
  } id_ex_t;

  typedef struct packed {
    logic                 valid;
    ctrl_t                ctrl;
    logic [REGNOBITS-1:0] wregno;
    logic [DBITS-1:0]     aluout;
    logic [DBITS-1:0]     regval2;
  } ex_mem_t;

  typedef struct packed {
    logic                 wr_reg;
    logic [REGNOBITS-1:0] wregno;
    logic [DBITS-1:0]     regval;
  } mem_wb_t;

  typedef struct packed {
    logic             taken;
    logic [DBITS-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic                    we;
    logic [MEM_IDX_BITS-1:0] index;
    logic [DBITS-1:0]        wdata;
  } mem_port_t;

  typedef struct packed {
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [APB_ABITS-1:0] paddr;
    logic [DBITS-1:0]     pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [DBITS-1:0] prdata;
    logic             pready;
    logic             pslverr;
  } apb_rsp_t;

endpackage
